// File: hdl/ex_pkg.sv
`default_nettype none

package ex_pkg;

	localparam int XLEN = 32;       // data and address width, one word
	localparam int REG_ADDR_W = 5;  // register index width
	localparam int NUM_REGS = 32;   // x0 is included but never stored
	localparam int SHAMT_W = 5;     // shifts use the low five bits of operand b
	localparam int PC_STEP = 4;     // one instruction word ahead, used for the link value

	// operation codes seen by the EX stage, four bits wide
	typedef enum logic [3:0] {
		ALU_OR   = 4'd0,
		ALU_XOR  = 4'd1,
		ALU_AND  = 4'd2,
		ALU_SLL  = 4'd3,
		ALU_SRL  = 4'd4,
		ALU_SRA  = 4'd5,
		ALU_ADD  = 4'd6,
		ALU_SUB  = 4'd7,
		ALU_SLT  = 4'd8,
		ALU_SLTU = 4'd9,
		ALU_JAL  = 4'd10,
		ALU_NOP  = 4'd11
	} alu_op_t;

	// result group that reaches write-back
	typedef enum logic [1:0] {
		RES_LOGIC = 2'd0,
		RES_SHIFT = 2'd1,
		RES_ARITH = 2'd2,
		RES_JB    = 2'd3
	} res_sel_t;

	typedef struct packed {
		logic [XLEN-1:0]       pc;
		alu_op_t               alu_op;
		res_sel_t              res_sel;
		logic [REG_ADDR_W-1:0] rs1;
		logic [REG_ADDR_W-1:0] rs2;
		logic [XLEN-1:0]       imm;
		logic                  use_imm;   // operand b comes from imm instead of rs2
		logic [REG_ADDR_W-1:0] rd;
		logic                  w_enable;
	} id_ex_t;

	typedef struct packed {
		logic                  w_enable;  // already qualified with valid and a non-zero rd
		logic [REG_ADDR_W-1:0] rd;
		logic [XLEN-1:0]       w_data;
		logic                  branch;
		logic [XLEN-1:0]       branch_target;
	} ex_wb_t;

endpackage

`default_nettype wire

// File: hdl/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
	input  wire                              clk,
	input  wire                              rst,
	input  wire                              we_i,
	input  wire [ex_pkg::REG_ADDR_W-1:0]     waddr_i,
	input  wire [ex_pkg::XLEN-1:0]           wdata_i,
	input  wire [ex_pkg::REG_ADDR_W-1:0]     raddr_a_i,
	input  wire [ex_pkg::REG_ADDR_W-1:0]     raddr_b_i,
	output logic [ex_pkg::XLEN-1:0]          rdata_a_o,
	output logic [ex_pkg::XLEN-1:0]          rdata_b_o
);

	logic [ex_pkg::XLEN-1:0] regs [1:ex_pkg::NUM_REGS-1];  // x0 has no storage

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 1; i < ex_pkg::NUM_REGS; i++)
				regs[i] <= '0;
		end
		else if (we_i && (waddr_i != '0))
		begin
			regs[waddr_i] <= wdata_i;
		end
	end

	always_comb
	begin
		rdata_a_o = (raddr_a_i == '0) ? '0 : regs[raddr_a_i];  // x0 is hard zero
		rdata_b_o = (raddr_b_i == '0) ? '0 : regs[raddr_b_i];
	end

	// the EX/WB stage drops writes to x0 before they get here
	no_x0_write: assert property (@(posedge clk) disable iff (rst)
		we_i |-> (waddr_i != '0))
		else $error("register file write enable with index 0");

endmodule

`default_nettype wire

// File: hdl/pipe_reg.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
	parameter type PAYLOAD_T = logic [31:0]
) (
	input  wire           clk,
	input  wire           rst,
	input  wire           valid_i,
	input  wire           squash_i,
	input  wire PAYLOAD_T data_i,
	output logic          valid_o,
	output PAYLOAD_T      data_o
);

	// valid is the only control state in a stage
	always_ff @(posedge clk)
	begin
		if (rst)
			valid_o <= 1'b0;
		else
			valid_o <= valid_i && !squash_i;  // a squashed slot becomes a bubble
	end

	always_ff @(posedge clk)
	begin
		data_o <= data_i;  // payload is only meaningful while valid_o is high
	end

	// downstream stages count on an empty pipe right after reset
	empty_after_rst: assert property (@(posedge clk)
		rst |=> !valid_o)
		else $error("pipeline stage valid after reset");

endmodule

`default_nettype wire

// File: hdl/operand_fwd.sv
`timescale 1ns/1ps
`default_nettype none

module operand_fwd (
	input  wire [ex_pkg::REG_ADDR_W-1:0] rs1_i,
	input  wire [ex_pkg::REG_ADDR_W-1:0] rs2_i,
	input  wire [ex_pkg::XLEN-1:0]       rf_a_i,
	input  wire [ex_pkg::XLEN-1:0]       rf_b_i,
	input  wire [ex_pkg::XLEN-1:0]       imm_i,
	input  wire                          use_imm_i,
	input  wire                          wb_valid_i,
	input  wire [ex_pkg::REG_ADDR_W-1:0] wb_rd_i,
	input  wire [ex_pkg::XLEN-1:0]       wb_data_i,
	output logic [ex_pkg::XLEN-1:0]      op_a_o,
	output logic [ex_pkg::XLEN-1:0]      op_b_o
);

	logic hit_a;
	logic hit_b;
	logic [ex_pkg::XLEN-1:0] src_b;

	// the EX/WB result has not reached the register file yet
	assign hit_a = wb_valid_i && (wb_rd_i != '0) && (wb_rd_i == rs1_i);
	assign hit_b = wb_valid_i && (wb_rd_i != '0) && (wb_rd_i == rs2_i);

	always_comb
	begin
		op_a_o = hit_a ? wb_data_i : rf_a_i;
		src_b = hit_b ? wb_data_i : rf_b_i;
		op_b_o = use_imm_i ? imm_i : src_b;  // immediate forms ignore rs2
	end

endmodule

`default_nettype wire

// File: hdl/ex_alu.sv
`timescale 1ns/1ps
`default_nettype none

module ex_alu (
	input  wire                          valid_i,
	input  wire [ex_pkg::XLEN-1:0]       pc_i,
	input  wire ex_pkg::alu_op_t         alu_op_i,
	input  wire ex_pkg::res_sel_t        res_sel_i,
	input  wire [ex_pkg::XLEN-1:0]       op_a_i,
	input  wire [ex_pkg::XLEN-1:0]       op_b_i,
	input  wire [ex_pkg::XLEN-1:0]       imm_i,
	input  wire [ex_pkg::REG_ADDR_W-1:0] rd_i,
	input  wire                          w_enable_i,
	output logic                         w_enable_o,
	output logic [ex_pkg::REG_ADDR_W-1:0] rd_o,
	output logic [ex_pkg::XLEN-1:0]      w_data_o,
	output logic                         branch_o,
	output logic [ex_pkg::XLEN-1:0]      branch_target_o
);

	logic [ex_pkg::XLEN-1:0]    logic_res;
	logic [ex_pkg::XLEN-1:0]    shift_res;
	logic [ex_pkg::XLEN-1:0]    arith_res;
	logic [ex_pkg::XLEN-1:0]    jb_res;
	logic [ex_pkg::SHAMT_W-1:0] shamt;
	logic [ex_pkg::XLEN-1:0]    sum;
	logic [ex_pkg::XLEN-1:0]    diff;
	logic                       lt_signed;
	logic                       lt_unsigned;

	assign shamt = op_b_i[ex_pkg::SHAMT_W-1:0];
	assign sum = op_a_i + op_b_i;
	assign diff = op_a_i - op_b_i;
	assign lt_signed = $signed(op_a_i) < $signed(op_b_i);
	assign lt_unsigned = op_a_i < op_b_i;

	always_comb
	begin
		case (alu_op_i)
			ex_pkg::ALU_OR:  logic_res = op_a_i | op_b_i;
			ex_pkg::ALU_XOR: logic_res = op_a_i ^ op_b_i;
			ex_pkg::ALU_AND: logic_res = op_a_i & op_b_i;
			default:         logic_res = '0;
		endcase
	end

	always_comb
	begin
		case (alu_op_i)
			ex_pkg::ALU_SLL: shift_res = op_a_i << shamt;
			ex_pkg::ALU_SRL: shift_res = op_a_i >> shamt;
			ex_pkg::ALU_SRA: shift_res = $unsigned($signed(op_a_i) >>> shamt);  // sign fills
			default:         shift_res = '0;
		endcase
	end

	always_comb
	begin
		case (alu_op_i)
			ex_pkg::ALU_ADD:  arith_res = sum;
			ex_pkg::ALU_SUB:  arith_res = diff;
			ex_pkg::ALU_SLT:  arith_res = {{(ex_pkg::XLEN-1){1'b0}}, lt_signed};
			ex_pkg::ALU_SLTU: arith_res = {{(ex_pkg::XLEN-1){1'b0}}, lt_unsigned};
			default:          arith_res = '0;
		endcase
	end

	// jal links the next sequential pc and jumps pc relative
	assign jb_res = (alu_op_i == ex_pkg::ALU_JAL) ? (pc_i + ex_pkg::PC_STEP) : '0;
	assign branch_o = valid_i && (alu_op_i == ex_pkg::ALU_JAL);
	assign branch_target_o = pc_i + imm_i;

	always_comb
	begin
		case (res_sel_i)
			ex_pkg::RES_LOGIC: w_data_o = logic_res;
			ex_pkg::RES_SHIFT: w_data_o = shift_res;
			ex_pkg::RES_ARITH: w_data_o = arith_res;
			ex_pkg::RES_JB:    w_data_o = jb_res;
			default:           w_data_o = '0;
		endcase
	end

	assign rd_o = rd_i;
	assign w_enable_o = w_enable_i && valid_i && (rd_i != '0);  // x0 writes never leave EX

	// decode must route a jal through the jump group or the link value is lost
	always_comb
	begin
		jal_uses_jb: assert #0 (!branch_o || (res_sel_i == ex_pkg::RES_JB))
			else $error("jal issued without the jump result group");
	end

endmodule

`default_nettype wire

// File: hdl/ex_cluster.sv
`timescale 1ns/1ps
`default_nettype none

module ex_cluster (
	input  wire                          clk,
	input  wire                          rst,
	input  wire                          issue_valid_i,
	input  wire [ex_pkg::XLEN-1:0]       pc_i,
	input  wire ex_pkg::alu_op_t         alu_op_i,
	input  wire ex_pkg::res_sel_t        res_sel_i,
	input  wire [ex_pkg::REG_ADDR_W-1:0] rs1_i,
	input  wire [ex_pkg::REG_ADDR_W-1:0] rs2_i,
	input  wire [ex_pkg::XLEN-1:0]       imm_i,
	input  wire                          use_imm_i,
	input  wire [ex_pkg::REG_ADDR_W-1:0] rd_i,
	input  wire                          w_enable_i,
	output logic                         wb_valid_o,
	output logic [ex_pkg::REG_ADDR_W-1:0] wb_addr_o,
	output logic [ex_pkg::XLEN-1:0]      wb_data_o,
	output logic                         redirect_o,
	output logic [ex_pkg::XLEN-1:0]      redirect_target_o
);

	ex_pkg::id_ex_t          id_in;
	ex_pkg::id_ex_t          ex_q;
	logic                    ex_valid;
	ex_pkg::ex_wb_t          wb_in;
	ex_pkg::ex_wb_t          wb_q;
	logic                    wb_valid;
	logic [ex_pkg::XLEN-1:0] rf_a;
	logic [ex_pkg::XLEN-1:0] rf_b;
	logic [ex_pkg::XLEN-1:0] op_a;
	logic [ex_pkg::XLEN-1:0] op_b;
	logic                    alu_branch;

	assign id_in = '{pc: pc_i, alu_op: alu_op_i, res_sel: res_sel_i, rs1: rs1_i, rs2: rs2_i,
		imm: imm_i, use_imm: use_imm_i, rd: rd_i, w_enable: w_enable_i};

	// a taken jal in EX turns the slot behind it into a bubble
	pipe_reg #(.PAYLOAD_T(ex_pkg::id_ex_t)) u_id_ex (
		.clk(clk), .rst(rst), .valid_i(issue_valid_i), .squash_i(alu_branch),
		.data_i(id_in), .valid_o(ex_valid), .data_o(ex_q)
	);

	reg_file u_rf (
		.clk(clk), .rst(rst), .we_i(wb_valid_o), .waddr_i(wb_q.rd), .wdata_i(wb_q.w_data),
		.raddr_a_i(ex_q.rs1), .raddr_b_i(ex_q.rs2), .rdata_a_o(rf_a), .rdata_b_o(rf_b)
	);

	operand_fwd u_fwd (
		.rs1_i(ex_q.rs1), .rs2_i(ex_q.rs2), .rf_a_i(rf_a), .rf_b_i(rf_b), .imm_i(ex_q.imm),
		.use_imm_i(ex_q.use_imm), .wb_valid_i(wb_valid_o), .wb_rd_i(wb_q.rd),
		.wb_data_i(wb_q.w_data), .op_a_o(op_a), .op_b_o(op_b)
	);

	ex_alu u_alu (
		.valid_i(ex_valid), .pc_i(ex_q.pc), .alu_op_i(ex_q.alu_op), .res_sel_i(ex_q.res_sel),
		.op_a_i(op_a), .op_b_i(op_b), .imm_i(ex_q.imm), .rd_i(ex_q.rd),
		.w_enable_i(ex_q.w_enable), .w_enable_o(wb_in.w_enable), .rd_o(wb_in.rd),
		.w_data_o(wb_in.w_data), .branch_o(alu_branch), .branch_target_o(wb_in.branch_target)
	);

	assign wb_in.branch = alu_branch;

	pipe_reg #(.PAYLOAD_T(ex_pkg::ex_wb_t)) u_ex_wb (
		.clk(clk), .rst(rst), .valid_i(ex_valid), .squash_i(1'b0),
		.data_i(wb_in), .valid_o(wb_valid), .data_o(wb_q)
	);

	// wb payload flags only count while the stage is valid
	assign wb_valid_o = wb_valid && wb_q.w_enable;
	assign wb_addr_o = wb_q.rd;
	assign wb_data_o = wb_q.w_data;
	assign redirect_o = wb_valid && wb_q.branch;
	assign redirect_target_o = wb_q.branch_target;

endmodule

`default_nettype wire

// File: dv/ex_checker.sv
`timescale 1ns/1ps
`default_nettype none

module ex_checker (
	input  wire                          clk,
	input  wire                          rst,
	input  wire                          issue_valid_i,
	input  wire [ex_pkg::XLEN-1:0]       pc_i,
	input  wire ex_pkg::alu_op_t         alu_op_i,
	input  wire ex_pkg::res_sel_t        res_sel_i,
	input  wire [ex_pkg::REG_ADDR_W-1:0] rs1_i, rs2_i, rd_i,
	input  wire [ex_pkg::XLEN-1:0]       imm_i,
	input  wire                          use_imm_i, w_enable_i,
	input  wire                          wb_valid_i, redirect_i,
	input  wire [ex_pkg::REG_ADDR_W-1:0] wb_addr_i,
	input  wire [ex_pkg::XLEN-1:0]       wb_data_i, redirect_target_i,
	output int                           pending_o, mismatches_o, missing_extra_o, checked_o
);

	typedef struct packed {
		logic [31:0]                   cyc;  // issue edge, counted from the end of reset
		logic                          wv;
		logic [ex_pkg::REG_ADDR_W-1:0] rd;
		logic [ex_pkg::XLEN-1:0]       data;
		logic                          redir;
		logic [ex_pkg::XLEN-1:0]       target;
	} expect_t;

	expect_t exp_q[$];
	logic [ex_pkg::XLEN-1:0] shadow [ex_pkg::NUM_REGS];  // architectural state in program order
	logic [31:0] cyc;
	logic prev_jal;  // last accepted issue was a jal, so this slot is a bubble
	int mismatches = 0;
	int missing_extra = 0;
	int checked = 0;

	assign mismatches_o = mismatches;
	assign missing_extra_o = missing_extra;
	assign checked_o = checked;

	// a select that names a group without this operation yields zero
	function automatic logic [31:0] ref_result(input ex_pkg::alu_op_t op,
		input ex_pkg::res_sel_t sel, input logic [31:0] a, input logic [31:0] b,
		input logic [31:0] pc);
		logic [4:0] s;
		logic [31:0] fill;
		logic slt;
		s = b[4:0];
		fill = a[31] ? ~(32'hffff_ffff >> s) : '0;  // sign bits shifted in from the top
		slt = (a[31] != b[31]) ? a[31] : (a < b);
		case (op)
			ex_pkg::ALU_OR:   return (sel == ex_pkg::RES_LOGIC) ? (a | b) : '0;
			ex_pkg::ALU_XOR:  return (sel == ex_pkg::RES_LOGIC) ? (a ^ b) : '0;
			ex_pkg::ALU_AND:  return (sel == ex_pkg::RES_LOGIC) ? (a & b) : '0;
			ex_pkg::ALU_SLL:  return (sel == ex_pkg::RES_SHIFT) ? (a << s) : '0;
			ex_pkg::ALU_SRL:  return (sel == ex_pkg::RES_SHIFT) ? (a >> s) : '0;
			ex_pkg::ALU_SRA:  return (sel == ex_pkg::RES_SHIFT) ? ((a >> s) | fill) : '0;
			ex_pkg::ALU_ADD:  return (sel == ex_pkg::RES_ARITH) ? (a + b) : '0;
			ex_pkg::ALU_SUB:  return (sel == ex_pkg::RES_ARITH) ? (a - b) : '0;
			ex_pkg::ALU_SLT:  return (sel == ex_pkg::RES_ARITH) ? {31'b0, slt} : '0;
			ex_pkg::ALU_SLTU: return (sel == ex_pkg::RES_ARITH) ? {31'b0, a < b} : '0;
			ex_pkg::ALU_JAL:  return (sel == ex_pkg::RES_JB) ? (pc + 32'd4) : '0;
			default:          return '0;
		endcase
	endfunction

	always @(posedge clk)
	begin
		expect_t e;
		logic [ex_pkg::XLEN-1:0] b;
		if (rst)
		begin
			if (wb_valid_i || redirect_i)
			begin
				$display("output valid while reset is held at %0t", $time);
				missing_extra++;
			end
			exp_q.delete();
			cyc = '0;
			prev_jal = 1'b0;
			for (int i = 0; i < ex_pkg::NUM_REGS; i++)
				shadow[i] = '0;
		end
		else
		begin
			if (exp_q.size() != 0 && exp_q[0].cyc + 32'd2 == cyc)  // due two edges after issue
			begin
				e = exp_q.pop_front();
				checked++;
				if (e.wv != wb_valid_i || e.redir != redirect_i)
				begin
					$display("missing or extra output at %0t for issue cycle %0d",
						$time, e.cyc);
					$display("got valid %0b redirect %0b, expected valid %0b redirect %0b",
						wb_valid_i, redirect_i, e.wv, e.redir);
					missing_extra++;
				end
				if (e.wv && wb_valid_i && (wb_addr_i != e.rd || wb_data_i != e.data))
				begin
					$display("** Error @%0t: write-back x%0d = %h, expected x%0d = %h",
						$time, wb_addr_i, wb_data_i, e.rd, e.data);
					mismatches++;
				end
				if (e.redir && redirect_i && redirect_target_i != e.target)
				begin
					$display("** Error @%0t: redirect target %h, expected %h",
						$time, redirect_target_i, e.target);
					mismatches++;
				end
			end
			else if (wb_valid_i || redirect_i)
			begin
				$display("extra output at %0t with no operation due in this cycle", $time);
				missing_extra++;
			end
			if (issue_valid_i && !prev_jal)
			begin
				b = use_imm_i ? imm_i : shadow[rs2_i];
				e.cyc = cyc;
				e.wv = w_enable_i && (rd_i != '0);
				e.rd = rd_i;
				e.data = ref_result(alu_op_i, res_sel_i, shadow[rs1_i], b, pc_i);
				e.redir = (alu_op_i == ex_pkg::ALU_JAL);
				e.target = pc_i + imm_i;
				if (e.wv)
					shadow[rd_i] = e.data;
				exp_q.push_back(e);
			end
			prev_jal = issue_valid_i && !prev_jal && (alu_op_i == ex_pkg::ALU_JAL);
			cyc = cyc + 32'd1;
		end
		pending_o = exp_q.size();
	end

endmodule

`default_nettype wire

// File: dv/ex_cluster_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ex_cluster_tb;

	localparam int NUM_OPS = 400;
	localparam logic [31:0] SEED = 32'h7153_9783;
	localparam int PERIOD_NS = 40;
	localparam int TIMEOUT_CYCLES = (NUM_OPS + 20) * 2;

	logic clk;
	logic rst;
	logic issue_valid;
	logic [ex_pkg::XLEN-1:0] pc;
	ex_pkg::alu_op_t alu_op;
	ex_pkg::res_sel_t res_sel;
	logic [ex_pkg::REG_ADDR_W-1:0] rs1, rs2, rd;
	logic [ex_pkg::XLEN-1:0] imm;
	logic use_imm;
	logic w_enable;
	logic wb_valid;
	logic [ex_pkg::REG_ADDR_W-1:0] wb_addr;
	logic [ex_pkg::XLEN-1:0] wb_data;
	logic redirect;
	logic [ex_pkg::XLEN-1:0] redirect_target;
	int pending, mismatches, missing_extra, checked;
	int cycles = 0;
	logic [31:0] lcg_state;

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// indices mostly fall in x0..x7 so neighbouring operations depend on each other
	task automatic drive_random_op(input int idx);
		logic [31:0] r1;
		logic [31:0] r2;
		lcg_state = lcg_next(lcg_state);
		r1 = lcg_state;
		lcg_state = lcg_next(lcg_state);
		r2 = lcg_state;
		lcg_state = lcg_next(lcg_state);
		issue_valid = r1[31:24] < 8'd205;  // about 80 percent of slots
		alu_op = ex_pkg::alu_op_t'(4'(r1[23:16] % 8'd12));
		if (alu_op == ex_pkg::ALU_JAL)
			res_sel = ex_pkg::RES_JB;
		else if (r1[15:12] == 4'hf)
			res_sel = ex_pkg::res_sel_t'(r1[1:0]);  // sometimes a group that lacks the op
		else if (alu_op >= ex_pkg::ALU_ADD)
			res_sel = ex_pkg::RES_ARITH;
		else if (alu_op >= ex_pkg::ALU_SLL)
			res_sel = ex_pkg::RES_SHIFT;
		else
			res_sel = ex_pkg::RES_LOGIC;
		rs1 = (r2[1:0] == 2'd3) ? r2[6:2] : {2'b00, r2[4:2]};
		rs2 = (r2[8:7] == 2'd3) ? r2[13:9] : {2'b00, r2[11:9]};
		rd = (r2[15:14] == 2'd3) ? r2[20:16] : {2'b00, r2[18:16]};
		use_imm = r1[11];
		w_enable = r1[10:8] != 3'd0;
		case (r1[7:5])
			3'd0: imm = '0;
			3'd1: imm = 32'd31;
			3'd2: imm = 32'hffff_ffff;  // shift by 31 and a negative operand
			3'd3: imm = 32'h8000_0000;
			default: imm = lcg_state;
		endcase
		pc = 32'h0000_1000 + 32'(idx) * 32'd4;
	endtask

	initial
	begin
		clk = 1'b0;
		forever
			#(PERIOD_NS / 2) clk = ~clk;
	end

	ex_cluster dut0 (
		.clk(clk), .rst(rst), .issue_valid_i(issue_valid), .pc_i(pc), .alu_op_i(alu_op),
		.res_sel_i(res_sel), .rs1_i(rs1), .rs2_i(rs2), .imm_i(imm), .use_imm_i(use_imm),
		.rd_i(rd), .w_enable_i(w_enable), .wb_valid_o(wb_valid), .wb_addr_o(wb_addr),
		.wb_data_o(wb_data), .redirect_o(redirect), .redirect_target_o(redirect_target)
	);

	ex_checker chk0 (
		.clk(clk), .rst(rst), .issue_valid_i(issue_valid), .pc_i(pc), .alu_op_i(alu_op),
		.res_sel_i(res_sel), .rs1_i(rs1), .rs2_i(rs2), .rd_i(rd), .imm_i(imm),
		.use_imm_i(use_imm), .w_enable_i(w_enable), .wb_valid_i(wb_valid),
		.redirect_i(redirect), .wb_addr_i(wb_addr), .wb_data_i(wb_data),
		.redirect_target_i(redirect_target), .pending_o(pending), .mismatches_o(mismatches),
		.missing_extra_o(missing_extra), .checked_o(checked)
	);

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES)
		begin
			$display("timeout after %0d cycles with %0d results still pending", cycles, pending);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	initial
	begin
		lcg_state = SEED;
		rst = 1'b1;
		issue_valid = 1'b0;
		pc = '0;
		alu_op = ex_pkg::ALU_NOP;
		res_sel = ex_pkg::RES_LOGIC;
		rs1 = '0;
		rs2 = '0;
		rd = '0;
		imm = '0;
		use_imm = 1'b0;
		w_enable = 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		for (int i = 0; i < NUM_OPS; i++)
		begin
			drive_random_op(i);
			@(negedge clk);
		end
		issue_valid = 1'b0;
		while (pending != 0)
			@(negedge clk);  // drain the two stages
		repeat (2) @(negedge clk);  // a trailing slot behind a jal would surface here
		$display("checked %0d results, %0d value errors, %0d missing or extra outputs",
			checked, mismatches, missing_extra);
		if (mismatches == 0 && missing_extra == 0 && checked > 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
hdl/ex_pkg.sv
hdl/reg_file.sv
hdl/pipe_reg.sv
hdl/operand_fwd.sv
hdl/ex_alu.sv
hdl/ex_cluster.sv
dv/ex_checker.sv
dv/ex_cluster_tb.sv

// File: Makefile
TOP       ?= ex_cluster_tb
LOG       ?= sim.log
VERILATOR ?= verilator
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing --assert -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
